// File: logic/nts_extractor_config.svh
// Build-time constants for the NTS packet extractor
// Data and address widths, buffer count, register map,
// core name and version words
`ifndef NTS_EXTRACTOR_CONFIG_SVH
`define NTS_EXTRACTOR_CONFIG_SVH

// Data path
`define NTS_WORD_W 64
// Word address inside one packet buffer
`define NTS_WORD_ADDR_W 8
// Buffer select, four buffers
`define NTS_BUF_SEL_W 2

// Register bus
`define NTS_API_ADDR_W 12
`define NTS_API_BASE 'h400

// Register offsets from the base
`define NTS_REG_NAME0 0
`define NTS_REG_NAME1 1
`define NTS_REG_VERSION 2
`define NTS_REG_BYTES 10
`define NTS_REG_PACKETS 12

// ASCII "NTS-EXTR" and "0.01"
`define NTS_CORE_NAME 64'h4e54_532d_4558_5452
`define NTS_CORE_VERSION 32'h302e_3031

`endif

// File: logic/nts_extractor_pkg.sv
// Shared types for the NTS packet extractor
// Data word, buffer RAM address, buffer state,
// buffer descriptor and RAM write bundle
`include "nts_extractor_config.svh"

package nts_extractor_pkg;

  // One engine or MAC data word
  typedef logic [`NTS_WORD_W-1:0] nts_word_t;

  // Buffer RAM address, buffer index above word address
  typedef logic [`NTS_BUF_SEL_W+`NTS_WORD_ADDR_W-1:0] nts_ram_addr_t;

  // Life cycle of one packet buffer
  typedef enum logic [1:0] {
    BUF_UNUSED  = 2'd0,
    BUF_WRITING = 2'd1,
    BUF_LOADED  = 2'd2
  } nts_buf_state_e;

  // Descriptor of the oldest loaded buffer
  // buf_idx follows the read pointer, also while valid is low
  typedef struct packed {
    logic                       valid;
    logic [`NTS_BUF_SEL_W-1:0]   buf_idx;
    logic [`NTS_WORD_ADDR_W-1:0] last_addr;
    // Bytes in the last word, 1 to 8
    logic [3:0]                 bytes_last;
  } nts_desc_t;

  // One write into the buffer RAM
  typedef struct packed {
    logic          en;
    nts_ram_addr_t addr;
    nts_word_t     data;
  } nts_ram_wr_t;

endpackage

// File: logic/nts_buffer_ram.sv
// Packet buffer RAM for the NTS extractor
// Engine side writes, MAC side reads with one cycle latency
`timescale 1ns/1ps

module nts_buffer_ram (
  input  logic                           i_clk,
  input  nts_extractor_pkg::nts_ram_wr_t   i_wr,
  input  nts_extractor_pkg::nts_ram_addr_t i_rd_addr,
  output nts_extractor_pkg::nts_word_t     o_rd_data
);
  import nts_extractor_pkg::*;

  // One entry per address, all four buffers back to back
  localparam int DEPTH = 1 << $bits(nts_ram_addr_t);

  nts_word_t mem [DEPTH];

  // Write port
  always_ff @(posedge i_clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // Registered read port, old data on a same-address collision
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

  // The reader's write register must never carry a floating address
  assert property (@(posedge i_clk) i_wr.en |-> !$isunknown(i_wr.addr))
    else $error("Buffer RAM write with unknown address");

endmodule

// File: logic/nts_engine_reader.sv
// Engine side of the NTS extractor
// Copies packets from the engine FIFO into free buffers in ring order
// and offers loaded buffers to the MAC side as descriptors
`timescale 1ns/1ps
`include "nts_extractor_config.svh"

module nts_engine_reader (
  input  logic                         i_clk,
  input  logic                         i_areset,
  input  logic                         i_engine_packet_available,
  output logic                         o_engine_packet_read,
  input  logic                         i_engine_fifo_empty,
  output logic                         o_engine_fifo_rd_en,
  input  nts_extractor_pkg::nts_word_t   i_engine_fifo_rd_data,
  input  logic [3:0]                   i_engine_bytes_last_word,
  output nts_extractor_pkg::nts_ram_wr_t o_ram_wr,
  output nts_extractor_pkg::nts_desc_t   o_desc,
  input  logic                         i_desc_done
);
  import nts_extractor_pkg::*;

  localparam int NBUF = 1 << `NTS_BUF_SEL_W;

  // Per-buffer bookkeeping
  nts_buf_state_e              buf_state [NBUF];
  logic [`NTS_WORD_ADDR_W-1:0] buf_addr  [NBUF];
  logic [`NTS_WORD_ADDR_W-1:0] buf_last  [NBUF];
  logic [3:0]                  buf_lwdv  [NBUF];

  // Ring pointers, fill side and drain side
  logic [`NTS_BUF_SEL_W-1:0] wr_ptr;
  logic [`NTS_BUF_SEL_W-1:0] rd_ptr;

  logic capture;
  logic pop;
  logic finish;

  // --------------------------------------------------------------------------
  // Engine handshake
  // --------------------------------------------------------------------------
  always_comb begin
    // New packet on a free buffer, no pop yet
    capture = (buf_state[wr_ptr] == BUF_UNUSED) && i_engine_packet_available;
    // Head word of a FWFT FIFO is taken in the same cycle
    pop = (buf_state[wr_ptr] == BUF_WRITING) && !i_engine_fifo_empty;
    // FIFO ran dry, packet complete
    finish = (buf_state[wr_ptr] == BUF_WRITING) && i_engine_fifo_empty;
  end

  assign o_engine_fifo_rd_en  = pop;
  assign o_engine_packet_read = finish;

  // Buffer states and pointers
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int b = 0; b < NBUF; b++) begin
        buf_state[b] <= BUF_UNUSED;
      end
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (capture) begin
        buf_state[wr_ptr] <= BUF_WRITING;
      end
      if (finish) begin
        buf_state[wr_ptr] <= BUF_LOADED;
        wr_ptr <= wr_ptr + 1'b1;
      end
      // MAC is done with the oldest buffer, hand it back
      if (i_desc_done) begin
        buf_state[rd_ptr] <= BUF_UNUSED;
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Word address, byte count and last address of the buffer being filled
  always_ff @(posedge i_clk) begin
    if (capture) begin
      buf_addr[wr_ptr] <= '0;
      buf_lwdv[wr_ptr] <= i_engine_bytes_last_word;
    end
    if (pop) begin
      buf_addr[wr_ptr] <= buf_addr[wr_ptr] + 1'b1;
    end
    if (finish) begin
      buf_last[wr_ptr] <= buf_addr[wr_ptr] - 1'b1;
    end
  end

  // RAM write, one register stage after the pop
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_ram_wr <= '0;
    end else begin
      o_ram_wr.en   <= pop;
      o_ram_wr.addr <= {wr_ptr, buf_addr[wr_ptr]};
      o_ram_wr.data <= i_engine_fifo_rd_data;
    end
  end

  // --------------------------------------------------------------------------
  // Descriptor of the oldest buffer
  // --------------------------------------------------------------------------
  always_comb begin
    o_desc.valid      = (buf_state[rd_ptr] == BUF_LOADED);
    o_desc.buf_idx    = rd_ptr;
    o_desc.last_addr  = buf_last[rd_ptr];
    o_desc.bytes_last = buf_lwdv[rd_ptr];
  end

  // Delayed write of the final word still lands inside the writing window
  assert property (@(posedge i_clk) disable iff (i_areset)
    o_ram_wr.en |-> buf_state[wr_ptr] == BUF_WRITING)
    else $error("RAM write outside a writing buffer");

endmodule

// File: logic/nts_mac_tx.sv
// MAC transmit side of the NTS extractor
// Streams the oldest loaded buffer with start, ack wait and a silent cycle
// Prefetches from the buffer RAM so words leave back to back
`timescale 1ns/1ps
`include "nts_extractor_config.svh"

module nts_mac_tx (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_extractor_pkg::nts_desc_t     i_desc,
  output logic                           o_desc_done,
  output nts_extractor_pkg::nts_ram_addr_t o_ram_rd_addr,
  input  nts_extractor_pkg::nts_word_t     i_ram_rd_data,
  output logic                           o_mac_tx_start,
  input  logic                           i_mac_tx_ack,
  output logic [7:0]                     o_mac_tx_data_valid,
  output nts_extractor_pkg::nts_word_t     o_mac_tx_data
);
  import nts_extractor_pkg::*;

  localparam int AW = `NTS_WORD_ADDR_W;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_AWAIT_ACK,
    TX_WRITE,
    TX_SILENT
  } tx_state_e;

  tx_state_e state;

  // Index of the word now on the MAC outputs
  logic [AW-1:0] out_idx;
  logic [AW-1:0] next_idx;
  logic [7:0]    next_mask;
  logic [AW-1:0] rd_word;
  logic [`NTS_BUF_SEL_W-1:0] rd_buf;

  // Byte k of the MAC word is byte 7-k of the stored word
  function automatic nts_word_t byte_reverse(input nts_word_t word, input logic [7:0] mask);
    nts_word_t res;
    for (int k = 0; k < 8; k++) begin
      res[8*k +: 8] = mask[k] ? word[8*(7-k) +: 8] : 8'h00;
    end
    return res;
  endfunction

  // Low n bits set for n valid bytes
  function automatic logic [7:0] expand_mask(input logic [3:0] count);
    logic [7:0] mask;
    for (int k = 0; k < 8; k++) begin
      mask[k] = (k < count);
    end
    return mask;
  endfunction

  // --------------------------------------------------------------------------
  // Read address, always one word ahead of what the RAM outputs
  // --------------------------------------------------------------------------
  always_comb begin
    next_idx  = out_idx + 1'b1;
    next_mask = (next_idx == i_desc.last_addr) ? expand_mask(i_desc.bytes_last) : 8'hff;
    rd_buf    = i_desc.buf_idx;
    rd_word   = '0;
    case (state)
      // Word 0 sits on the RAM output, fetch word 1 on start
      TX_IDLE:      rd_word = i_desc.valid ? AW'(1) : AW'(0);
      TX_AWAIT_ACK: rd_word = i_mac_tx_ack ? AW'(2) : AW'(1);
      TX_WRITE:     rd_word = out_idx + AW'(2);
      // Word 0 of the next buffer in ring order
      TX_SILENT:    rd_buf = i_desc.buf_idx + 1'b1;
      default:      rd_word = '0;
    endcase
  end

  assign o_ram_rd_addr = {rd_buf, rd_word};
  assign o_desc_done   = (state == TX_SILENT);

  // --------------------------------------------------------------------------
  // Transmit FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state               <= TX_IDLE;
      out_idx             <= '0;
      o_mac_tx_start      <= 1'b0;
      o_mac_tx_data_valid <= '0;
      o_mac_tx_data       <= '0;
    end else begin
      o_mac_tx_start <= 1'b0;
      case (state)
        TX_IDLE: begin
          o_mac_tx_data_valid <= '0;
          o_mac_tx_data       <= '0;
          if (i_desc.valid) begin
            o_mac_tx_start      <= 1'b1;
            o_mac_tx_data_valid <= 8'hff;
            o_mac_tx_data       <= byte_reverse(i_ram_rd_data, 8'hff);
            out_idx             <= '0;
            state               <= TX_AWAIT_ACK;
          end
        end
        // Word 0 holds until the MAC accepts
        TX_AWAIT_ACK: begin
          if (i_mac_tx_ack) begin
            out_idx             <= next_idx;
            o_mac_tx_data_valid <= next_mask;
            o_mac_tx_data       <= byte_reverse(i_ram_rd_data, next_mask);
            state               <= TX_WRITE;
          end
        end
        TX_WRITE: begin
          if (out_idx == i_desc.last_addr) begin
            // End of packet, one idle word for the MAC
            o_mac_tx_data_valid <= '0;
            o_mac_tx_data       <= '0;
            state               <= TX_SILENT;
          end else begin
            out_idx             <= next_idx;
            o_mac_tx_data_valid <= next_mask;
            o_mac_tx_data       <= byte_reverse(i_ram_rd_data, next_mask);
          end
        end
        TX_SILENT: state <= TX_IDLE;
        default:   state <= TX_IDLE;
      endcase
    end
  end

  // Nothing leaks onto the MAC between packets
  assert property (@(posedge i_clk) disable iff (i_areset)
    state == TX_IDLE |-> o_mac_tx_data_valid == 8'h00)
    else $error("MAC data valid set while idle");

endmodule

// File: logic/nts_api_regs.sv
// Register bank of the NTS extractor
// Core name and version, 64-bit byte and packet counters
// Upper word read snapshots the lower word for the next read
`timescale 1ns/1ps
`include "nts_extractor_config.svh"

module nts_api_regs (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_api_cs,
  input  logic                       i_api_we,
  input  logic [`NTS_API_ADDR_W-1:0] i_api_address,
  output logic [31:0]                o_api_read_data,
  input  logic                       i_mac_tx_start,
  input  logic [7:0]                 i_mac_tx_data_valid
);
  localparam int AW = `NTS_API_ADDR_W;

  // Absolute register addresses
  localparam logic [AW-1:0] ADDR_NAME0   = AW'(`NTS_API_BASE + `NTS_REG_NAME0);
  localparam logic [AW-1:0] ADDR_NAME1   = AW'(`NTS_API_BASE + `NTS_REG_NAME1);
  localparam logic [AW-1:0] ADDR_VERSION = AW'(`NTS_API_BASE + `NTS_REG_VERSION);
  localparam logic [AW-1:0] ADDR_BYTES   = AW'(`NTS_API_BASE + `NTS_REG_BYTES);
  localparam logic [AW-1:0] ADDR_PACKETS = AW'(`NTS_API_BASE + `NTS_REG_PACKETS);

  localparam logic [63:0] CORE_NAME    = `NTS_CORE_NAME;
  localparam logic [31:0] CORE_VERSION = `NTS_CORE_VERSION;

  logic [63:0] bytes_cnt;
  logic [63:0] packets_cnt;
  logic [31:0] bytes_lo_snap;
  logic [31:0] packets_lo_snap;
  logic        snap_bytes;
  logic        snap_packets;

  // --------------------------------------------------------------------------
  // Combinational read decode
  // --------------------------------------------------------------------------
  always_comb begin
    o_api_read_data = '0;
    snap_bytes      = 1'b0;
    snap_packets    = 1'b0;
    // Writes and unmapped addresses read as zero
    if (i_api_cs && !i_api_we) begin
      case (i_api_address)
        ADDR_NAME0:   o_api_read_data = CORE_NAME[63:32];
        ADDR_NAME1:   o_api_read_data = CORE_NAME[31:0];
        ADDR_VERSION: o_api_read_data = CORE_VERSION;
        ADDR_BYTES: begin
          o_api_read_data = bytes_cnt[63:32];
          snap_bytes      = 1'b1;
        end
        ADDR_BYTES + AW'(1): o_api_read_data = bytes_lo_snap;
        ADDR_PACKETS: begin
          o_api_read_data = packets_cnt[63:32];
          snap_packets    = 1'b1;
        end
        ADDR_PACKETS + AW'(1): o_api_read_data = packets_lo_snap;
        default: o_api_read_data = '0;
      endcase
    end
  end

  // Statistics from the MAC stream, mask popcount per cycle
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      bytes_cnt       <= '0;
      packets_cnt     <= '0;
      bytes_lo_snap   <= '0;
      packets_lo_snap <= '0;
    end else begin
      bytes_cnt <= bytes_cnt + 64'($countones(i_mac_tx_data_valid));
      if (i_mac_tx_start) begin
        packets_cnt <= packets_cnt + 1'b1;
      end
      if (snap_bytes) begin
        bytes_lo_snap <= bytes_cnt[31:0];
      end
      if (snap_packets) begin
        packets_lo_snap <= packets_cnt[31:0];
      end
    end
  end

endmodule

// File: logic/nts_extractor.sv
// NTS packet extractor top level
// Engine reader and MAC transmitter share the buffer RAM,
// the register bank watches the MAC stream
`timescale 1ns/1ps
`include "nts_extractor_config.svh"

module nts_extractor (
  input  logic                       i_clk,
  input  logic                       i_areset,
  // Register bus
  input  logic                       i_api_cs,
  input  logic                       i_api_we,
  input  logic [`NTS_API_ADDR_W-1:0] i_api_address,
  output logic [31:0]                o_api_read_data,
  // Engine FIFO
  input  logic                       i_engine_packet_available,
  output logic                       o_engine_packet_read,
  input  logic                       i_engine_fifo_empty,
  output logic                       o_engine_fifo_rd_en,
  input  nts_extractor_pkg::nts_word_t i_engine_fifo_rd_data,
  input  logic [3:0]                 i_engine_bytes_last_word,
  // MAC transmitter
  output logic                       o_mac_tx_start,
  input  logic                       i_mac_tx_ack,
  output logic [7:0]                 o_mac_tx_data_valid,
  output nts_extractor_pkg::nts_word_t o_mac_tx_data
);
  import nts_extractor_pkg::*;

  nts_ram_wr_t   ram_wr;
  nts_desc_t     desc;
  logic          desc_done;
  nts_ram_addr_t ram_rd_addr;
  nts_word_t     ram_rd_data;

  // Fill side
  nts_engine_reader u_engine_reader (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .i_engine_packet_available (i_engine_packet_available),
    .o_engine_packet_read      (o_engine_packet_read),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_ram_wr                  (ram_wr),
    .o_desc                    (desc),
    .i_desc_done               (desc_done)
  );

  nts_buffer_ram u_buffer_ram (
    .i_clk     (i_clk),
    .i_wr      (ram_wr),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (ram_rd_data)
  );

  // Drain side
  nts_mac_tx u_mac_tx (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_desc              (desc),
    .o_desc_done         (desc_done),
    .o_ram_rd_addr       (ram_rd_addr),
    .i_ram_rd_data       (ram_rd_data),
    .o_mac_tx_start      (o_mac_tx_start),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data)
  );

  nts_api_regs u_api_regs (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_api_cs            (i_api_cs),
    .i_api_we            (i_api_we),
    .i_api_address       (i_api_address),
    .o_api_read_data     (o_api_read_data),
    .i_mac_tx_start      (o_mac_tx_start),
    .i_mac_tx_data_valid (o_mac_tx_data_valid)
  );

endmodule

// File: dv/tb_nts_extractor.sv
// Testbench for the NTS packet extractor
// Engine FIFO model, MAC ack model, byte scoreboard,
// register bank checks, stall test and a cycle timeout
`timescale 1ns/1ps
`include "nts_extractor_config.svh"

module tb_nts_extractor;
  import nts_extractor_pkg::*;

  localparam int NUM_PKTS       = 20;
  localparam int NBUF           = 1 << `NTS_BUF_SEL_W;
  // Packet whose ack is withheld long enough to fill every buffer
  localparam int HOLD_PKT       = 8;
  localparam int HOLD_CYCLES    = 200;
  localparam int QUIET_CYCLES   = 80;
  localparam int TIMEOUT_CYCLES = 200 * NUM_PKTS + 500;

  // Monitor states
  localparam int MON_IDLE   = 0;
  localparam int MON_AWAIT  = 1;
  localparam int MON_STREAM = 2;
  localparam int MON_SILENT = 3;
  localparam int MON_GAP    = 4;

  logic                       i_clk;
  logic                       i_areset;
  logic                       i_api_cs;
  logic                       i_api_we;
  logic [`NTS_API_ADDR_W-1:0] i_api_address;
  logic [31:0]                o_api_read_data;
  logic                       i_engine_packet_available;
  logic                       o_engine_packet_read;
  logic                       i_engine_fifo_empty;
  logic                       o_engine_fifo_rd_en;
  nts_word_t                  i_engine_fifo_rd_data;
  logic [3:0]                 i_engine_bytes_last_word;
  logic                       o_mac_tx_start;
  logic                       i_mac_tx_ack;
  logic [7:0]                 o_mac_tx_data_valid;
  nts_word_t                  o_mac_tx_data;

  integer      seed = 66109;
  // Scoreboard and per-packet expectations, filled at load time
  logic [7:0]  expected_bytes [$];
  int          pkt_words_q [$];
  int          pkt_last_q [$];
  int          ack_delay_q [$];
  nts_word_t   fifo_q [$];
  logic [63:0] total_bytes  = '0;
  int          pkts_loaded  = 0;
  int          packets_read = 0;
  int          packets_done = 0;
  int          cycle_count  = 0;
  logic        engine_on    = 1'b0;
  logic        popped       = 1'b0;
  logic        read_seen    = 1'b0;
  logic        quiet_window;
  int          mon_state    = MON_IDLE;
  int          cur_words;
  int          cur_last;
  int          word_idx;
  nts_word_t   held_data;
  logic [7:0]  held_mask;

  nts_extractor dut (.*);

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic stop_on_failure(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp)
      else stop_on_failure($sformatf("Error %s expected %h got %h", name, exp, got));
  endtask

  // n valid bytes sit in the low n lanes
  function automatic logic [7:0] low_bits_mask(input int count);
    return 8'((16'd1 << count) - 16'd1);
  endfunction

  // Lane k carries the next stream byte, empty lanes read zero
  task automatic check_word(input nts_word_t data, input logic [7:0] mask);
    logic [7:0] exp_byte;
    for (int k = 0; k < 8; k++) begin
      if (!mask[k]) begin
        expect_eq($sformatf("o_mac_tx_data byte %0d", k), 64'h0, 64'(data[8*k +: 8]));
      end else if (expected_bytes.size() == 0) begin
        stop_on_failure("MAC sent a byte that was never loaded into the engine FIFO");
      end else begin
        exp_byte = expected_bytes.pop_front();
        expect_eq($sformatf("o_mac_tx_data byte %0d", k), 64'(exp_byte), 64'(data[8*k +: 8]));
      end
    end
  endtask

  // One random packet into the FIFO model and the scoreboard
  task automatic load_packet();
    int        words;
    int        last_bytes;
    int        count;
    int        delay;
    nts_word_t word;
    words      = 2 + ({$random(seed)} % 11);
    last_bytes = 1 + ({$random(seed)} % 8);
    delay      = (pkts_loaded == HOLD_PKT) ? HOLD_CYCLES : ({$random(seed)} % 6);
    for (int w = 0; w < words; w++) begin
      word  = {$random(seed), $random(seed)};
      count = (w == words - 1) ? last_bytes : 8;
      fifo_q.push_back(word);
      // Stream order starts at the top byte of each stored word
      for (int b = 0; b < count; b++) begin
        expected_bytes.push_back(word[8*(7-b) +: 8]);
      end
    end
    pkt_words_q.push_back(words);
    pkt_last_q.push_back(last_bytes);
    ack_delay_q.push_back(delay);
    // Word 0 is counted again for every cycle it waits for ack
    total_bytes += 64'((words - 1) * 8 + last_bytes + 8 * delay);
    i_engine_bytes_last_word  = 4'(last_bytes);
    i_engine_packet_available = 1'b1;
    pkts_loaded++;
  endtask

  // Combinational read, sampled at the rising edge
  task automatic api_read(input int offset, output logic [31:0] data);
    @(negedge i_clk);
    i_api_cs      = 1'b1;
    i_api_we      = 1'b0;
    i_api_address = `NTS_API_ADDR_W'(`NTS_API_BASE + offset);
    @(posedge i_clk);
    data = o_api_read_data;
    @(negedge i_clk);
    i_api_cs = 1'b0;
  endtask

  initial begin : clock_gen
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // Engine FIFO model, first word falls through
  // --------------------------------------------------------------------------
  initial begin : engine_model
    i_engine_packet_available = 1'b0;
    i_engine_fifo_empty       = 1'b1;
    i_engine_fifo_rd_data     = '0;
    i_engine_bytes_last_word  = '0;
    wait (engine_on);
    forever begin
      @(negedge i_clk);
      if (popped) begin
        fifo_q.delete(0);
      end
      // Drop available after the read pulse, refill a cycle later
      if (read_seen) begin
        i_engine_packet_available = 1'b0;
      end else if (!i_engine_packet_available && pkts_loaded < NUM_PKTS) begin
        load_packet();
      end
      i_engine_fifo_empty   = (fifo_q.size() == 0);
      i_engine_fifo_rd_data = i_engine_fifo_empty ? '0 : fifo_q[0];
    end
  end

  // MAC ack model, one pulse per start after the packet's delay
  initial begin : ack_model
    int delay;
    i_mac_tx_ack = 1'b0;
    quiet_window = 1'b0;
    forever begin
      @(negedge i_clk);
      if (o_mac_tx_start) begin
        delay = ack_delay_q.pop_front();
        if (delay > QUIET_CYCLES) begin
          repeat (delay - QUIET_CYCLES) @(negedge i_clk);
          // All buffers loaded by now, the reader must stay put
          quiet_window = 1'b1;
          repeat (QUIET_CYCLES) @(negedge i_clk);
          quiet_window = 1'b0;
          expect_eq("o_engine_packet_read count", 64'(HOLD_PKT + NBUF), 64'(packets_read));
        end else begin
          repeat (delay) @(negedge i_clk);
        end
        i_mac_tx_ack = 1'b1;
        @(negedge i_clk);
        i_mac_tx_ack = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // MAC stream monitor
  // --------------------------------------------------------------------------
  always @(posedge i_clk) begin : mac_monitor
    popped    <= o_engine_fifo_rd_en;
    read_seen <= o_engine_packet_read;
    if (o_engine_packet_read) begin
      packets_read++;
    end
    if (quiet_window && (o_engine_fifo_rd_en || o_engine_packet_read)) begin
      stop_on_failure("Reader took a packet while all four buffers were loaded");
    end
    if (!i_areset) begin
      case (mon_state)
        MON_IDLE: begin
          if (!o_mac_tx_start) begin
            expect_eq("o_mac_tx_data_valid", 64'h0, 64'(o_mac_tx_data_valid));
          end else if (pkt_words_q.size() == 0) begin
            stop_on_failure("Start pulse without a pending packet");
          end else begin
            cur_words = pkt_words_q.pop_front();
            cur_last  = pkt_last_q.pop_front();
            expect_eq("o_mac_tx_data_valid", 64'hff, 64'(o_mac_tx_data_valid));
            check_word(o_mac_tx_data, o_mac_tx_data_valid);
            held_data = o_mac_tx_data;
            held_mask = o_mac_tx_data_valid;
            word_idx  = 1;
            mon_state = i_mac_tx_ack ? MON_STREAM : MON_AWAIT;
          end
        end
        // Word 0 frozen until ack
        MON_AWAIT: begin
          expect_eq("o_mac_tx_start", 64'h0, 64'(o_mac_tx_start));
          expect_eq("o_mac_tx_data", 64'(held_data), 64'(o_mac_tx_data));
          expect_eq("o_mac_tx_data_valid", 64'(held_mask), 64'(o_mac_tx_data_valid));
          if (i_mac_tx_ack) begin
            mon_state = MON_STREAM;
          end
        end
        MON_STREAM: begin
          expect_eq("o_mac_tx_start", 64'h0, 64'(o_mac_tx_start));
          expect_eq("o_mac_tx_data_valid",
                    64'((word_idx == cur_words - 1) ? low_bits_mask(cur_last) : 8'hff),
                    64'(o_mac_tx_data_valid));
          check_word(o_mac_tx_data, o_mac_tx_data_valid);
          if (word_idx == cur_words - 1) begin
            mon_state = MON_SILENT;
          end
          word_idx++;
        end
        MON_SILENT: begin
          expect_eq("o_mac_tx_data_valid", 64'h0, 64'(o_mac_tx_data_valid));
          expect_eq("o_mac_tx_data", 64'h0, 64'(o_mac_tx_data));
          packets_done++;
          mon_state = MON_GAP;
        end
        // No start right after the silent cycle
        default: begin
          expect_eq("o_mac_tx_start", 64'h0, 64'(o_mac_tx_start));
          mon_state = MON_IDLE;
        end
      endcase
    end
  end

  // Single-cycle pulses and no pop from an empty FIFO
  assert property (@(posedge i_clk) disable iff (i_areset) o_mac_tx_start |=> !o_mac_tx_start)
    else stop_on_failure("Start pulse longer than one cycle");
  assert property (@(posedge i_clk) disable iff (i_areset)
    o_engine_packet_read |=> !o_engine_packet_read)
    else stop_on_failure("Packet read pulse longer than one cycle");
  assert property (@(posedge i_clk) disable iff (i_areset)
    o_engine_fifo_rd_en |-> !i_engine_fifo_empty)
    else stop_on_failure("Engine FIFO popped while empty");

  always @(posedge i_clk) begin : watchdog
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_on_failure("Timeout, the packet stream did not finish in time");
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : main_seq
    logic [31:0] rd_hi;
    logic [31:0] rd_lo;
    i_areset      = 1'b1;
    i_api_cs      = 1'b0;
    i_api_we      = 1'b0;
    i_api_address = '0;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_areset = 1'b0;
    expect_eq("o_mac_tx_start", 64'h0, 64'(o_mac_tx_start));
    expect_eq("o_mac_tx_data_valid", 64'h0, 64'(o_mac_tx_data_valid));
    expect_eq("o_engine_fifo_rd_en", 64'h0, 64'(o_engine_fifo_rd_en));
    expect_eq("o_engine_packet_read", 64'h0, 64'(o_engine_packet_read));
    // Name and version as ASCII words
    api_read(`NTS_REG_NAME0, rd_hi);
    expect_eq("o_api_read_data", 64'("NTS-"), 64'(rd_hi));
    api_read(`NTS_REG_NAME1, rd_hi);
    expect_eq("o_api_read_data", 64'("EXTR"), 64'(rd_hi));
    api_read(`NTS_REG_VERSION, rd_hi);
    expect_eq("o_api_read_data", 64'("0.01"), 64'(rd_hi));
    api_read(5, rd_hi);
    expect_eq("o_api_read_data", 64'h0, 64'(rd_hi));
    engine_on = 1'b1;
    wait (packets_done == NUM_PKTS);
    repeat (4) @(negedge i_clk);
    // Upper word first, it snapshots the lower word
    api_read(`NTS_REG_PACKETS, rd_hi);
    api_read(`NTS_REG_PACKETS + 1, rd_lo);
    expect_eq("packet counter", 64'(NUM_PKTS), {rd_hi, rd_lo});
    api_read(`NTS_REG_BYTES, rd_hi);
    api_read(`NTS_REG_BYTES + 1, rd_lo);
    expect_eq("byte counter", total_bytes, {rd_hi, rd_lo});
    if (expected_bytes.size() != 0) begin
      stop_on_failure("Bytes left in the scoreboard at the end of the run");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+logic
logic/nts_extractor_pkg.sv
logic/nts_buffer_ram.sv
logic/nts_engine_reader.sv
logic/nts_mac_tx.sv
logic/nts_api_regs.sv
logic/nts_extractor.sv
dv/tb_nts_extractor.sv

// File: Makefile
# Verilator flow for the NTS packet extractor
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_nts_extractor
RTL_TOP   ?= nts_extractor
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

# Lint the design hierarchy only
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
